// File: compile.f
source/fifoPkg.sv
source/dpMemDc.sv
source/grayPtrSync.sv
source/fifoWriteSide.sv
source/fifoReadSide.sv
source/dcFifoTop.sv
verification/tbClockGen.sv
verification/dcFifoTb.sv

// File: Bender.yml
package:
  name: dc_fifo

dependencies: {}

sources:
  # Design sources in compile order, top level dcFifoTop
  - source/fifoPkg.sv
  - source/dpMemDc.sv
  - source/grayPtrSync.sv
  - source/fifoWriteSide.sv
  - source/fifoReadSide.sv
  - source/dcFifoTop.sv

  # Testbench, top module dcFifoTb
  - target: test
    files:
      - verification/tbClockGen.sv
      - verification/dcFifoTb.sv

// File: verification/dcFifoTb.sv
/*
  Checks order, frame flags, full and back-pressure of dcFifoTop with ADDR_WIDTH 4.
  The clocks run at 10 and 14 time units so the two domains drift against each other.
*/
module dcFifoTb;

  localparam int ADDR_WIDTH    = 4;
  localparam int NUM_WORDS     = 300;
  // Memory depth plus the two words held in the read side stages
  localparam int FULL_WORDS    = 2**ADDR_WIDTH + 2;
  localparam int WATCHDOG_TIME = (NUM_WORDS + FULL_WORDS + 1) * 40 + 5000;
  localparam int ACCEPT_LIMIT  = 200;
  localparam int DRAIN_LIMIT   = 1000;
  localparam int EXTRA_CYCLES  = 30;
  // Behaviors of the consumer process
  localparam int READ_STALL    = 0;
  localparam int READ_RANDOM   = 1;
  localparam int READ_ALWAYS   = 2;

  logic               wrClk;
  logic               rdClk;
  logic               rst;
  logic               wrValid;
  logic               wrReady;
  logic               rdValid;
  logic               rdReady;
  fifoPkg::fifoWord_t wrWord;
  fifoPkg::fifoWord_t rdWord;

  // Words accepted by the DUT and not yet read, oldest first
  fifoPkg::fifoWord_t refQueue [$];
  int                 errors       = 0;
  int                 wordsWritten = 0;
  int                 wordsRead    = 0;
  int                 readMode     = READ_STALL;
  fifoPkg::fifoWord_t expWord;
  // Output seen on the previous rdClk edge while stalled
  fifoPkg::fifoWord_t heldWord;
  logic               holdValid    = 1'b0;

  tbClockGen #(.PERIOD(10)) rdClkGen_i (.clk(rdClk));
  tbClockGen #(.PERIOD(14)) wrClkGen_i (.clk(wrClk));

  dcFifoTop #(.ADDR_WIDTH(ADDR_WIDTH)) dut_i (
    .wrClk  (wrClk),
    .rdClk  (rdClk),
    .rst    (rst),
    .wrValid(wrValid),
    .wrReady(wrReady),
    .wrWord (wrWord),
    .rdValid(rdValid),
    .rdReady(rdReady),
    .rdWord (rdWord)
  );

  ////////////////////////////////////////////////////////////
  // Reference model and helpers
  ////////////////////////////////////////////////////////////

  // Words must leave in the order they were accepted, so the expected
  // Word is always the oldest one still stored
  function automatic fifoPkg::fifoWord_t expectedWord();
    return refQueue.pop_front();
  endfunction

  // Random byte with the frame flag set on about one word in six
  function automatic fifoPkg::fifoWord_t randomWord();
    fifoPkg::fifoWord_t word;
    logic [31:0]        bits;
    bits      = $urandom;
    word.data = bits[fifoPkg::WORD_WIDTH-1:0];
    word.last = ($urandom_range(0, 5) == 0);
    return word;
  endfunction

  // Called on a falling wrClk edge and returns on one
  task automatic sendWord(input fifoPkg::fifoWord_t word, input bit withGaps);
    int cycles;
    bit taken;
    if (withGaps) begin
      while ($urandom_range(0, 3) == 0) begin
        @(negedge wrClk);
      end
    end
    wrValid = 1'b1;
    wrWord  = word;
    cycles  = 0;
    taken   = 1'b0;
    while (!taken && cycles < ACCEPT_LIMIT) begin
      @(posedge wrClk);
      cycles++;
      taken = (wrReady === 1'b1);
    end
    if (taken) begin
      refQueue.push_back(word);
      wordsWritten++;
    end else begin
      $display("%0t: a write was not accepted within %0d wrClk cycles", $time, ACCEPT_LIMIT);
      errors++;
    end
    @(negedge wrClk);
    wrValid = 1'b0;
  endtask

  // Holds one more word on the write port of a full FIFO, which must refuse it
  task automatic offerExtraWord();
    fifoPkg::fifoWord_t word;
    int                 cycles;
    bit                 taken;
    word    = randomWord();
    wrValid = 1'b1;
    wrWord  = word;
    cycles  = 0;
    taken   = 1'b0;
    while (!taken && cycles < EXTRA_CYCLES) begin
      @(posedge wrClk);
      cycles++;
      if (wrReady !== 1'b0) begin
        $display("CHECK FAILED at %0t: wrReady expected 0 got %b with %0d words stored",
                 $time, wrReady, refQueue.size());
        errors++;
        taken = (wrReady === 1'b1);
      end
    end
    // A wrongly accepted word still has to come out in order
    if (taken) begin
      refQueue.push_back(word);
      wordsWritten++;
    end
    @(negedge wrClk);
    wrValid = 1'b0;
  endtask

  // Changed on a rising edge so the consumer picks it up on the next falling edge
  task automatic setReadMode(input int mode);
    @(posedge rdClk);
    readMode = mode;
  endtask

  task automatic waitDrained();
    int cycles;
    cycles = 0;
    while (refQueue.size() != 0 && cycles < DRAIN_LIMIT) begin
      @(posedge rdClk);
      cycles++;
    end
    if (refQueue.size() != 0) begin
      $display("%0t: %0d words did not come out within %0d rdClk cycles",
               $time, refQueue.size(), DRAIN_LIMIT);
      errors++;
    end
    repeat (5) @(posedge rdClk);
  endtask

  task automatic checkNoOutput(input string when);
    if (rdValid !== 1'b0) begin
      $display("CHECK FAILED at %0t: rdValid expected 0 got %b %s", $time, rdValid, when);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Consumer and comparing process
  ////////////////////////////////////////////////////////////

  // The consumer drives rdReady on falling rdClk edges
  initial begin
    rdReady = 1'b0;
    forever begin
      @(negedge rdClk);
      if (rst) begin
        rdReady = 1'b0;
      end else if (readMode == READ_RANDOM) begin
        rdReady = ($urandom_range(0, 9) < 7);
      end else begin
        rdReady = (readMode == READ_ALWAYS);
      end
    end
  end

  // Values read here are the ones that stood before the edge
  always @(posedge rdClk) begin
    if (rst === 1'b0) begin
      if (rdValid === 1'b1 && rdReady === 1'b1) begin
        if (refQueue.size() == 0) begin
          $display("%0t: a read handshake happened with no word stored", $time);
          errors++;
        end else begin
          expWord = expectedWord();
          wordsRead++;
          if (rdWord.data !== expWord.data) begin
            $display("CHECK FAILED at %0t: rdWord.data expected %h got %h (read stage %s)",
                     $time, expWord.data, rdWord.data, dut_i.readSide_i.state.name());
            errors++;
          end
          if (rdWord.last !== expWord.last) begin
            $display("CHECK FAILED at %0t: rdWord.last expected %b got %b (read stage %s)",
                     $time, expWord.last, rdWord.last, dut_i.readSide_i.state.name());
            errors++;
          end
        end
      end
      // A stalled word must stay put until the consumer takes it
      if (holdValid) begin
        if (rdValid !== 1'b1) begin
          $display("CHECK FAILED at %0t: rdValid expected 1 got %b under back-pressure",
                   $time, rdValid);
          errors++;
        end else if (rdWord !== heldWord) begin
          $display("CHECK FAILED at %0t: rdWord expected %h got %h under back-pressure",
                   $time, heldWord, rdWord);
          errors++;
        end
      end
    end
    holdValid = (rst === 1'b0) && (rdValid === 1'b1) && (rdReady === 1'b0);
    heldWord  = rdWord;
  end

  ////////////////////////////////////////////////////////////
  // Stimulus and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(54419));
    rst     = 1'b1;
    wrValid = 1'b0;
    wrWord  = '0;
    // Reset spans 5 rdClk edges and so at least 3 wrClk edges
    repeat (5) begin
      @(negedge rdClk);
      checkNoOutput("during reset");
    end
    rst = 1'b0;
    @(negedge rdClk);
    checkNoOutput("on the first cycle after reset");
    @(negedge wrClk);
    if (wrReady !== 1'b1) begin
      $display("CHECK FAILED at %0t: wrReady expected 1 got %b after reset", $time, wrReady);
      errors++;
    end
    // Nothing has been written so nothing may appear
    setReadMode(READ_ALWAYS);
    repeat (10) begin
      @(negedge rdClk);
      checkNoOutput("before the first write");
    end

    // Random traffic with gaps on both sides
    setReadMode(READ_RANDOM);
    @(negedge wrClk);
    for (int i = 0; i < NUM_WORDS; i++) begin
      sendWord(randomWord(), 1'b1);
    end
    waitDrained();

    // Fill against a stalled consumer, then drain
    setReadMode(READ_STALL);
    @(negedge wrClk);
    for (int i = 0; i < FULL_WORDS; i++) begin
      sendWord(randomWord(), 1'b0);
    end
    offerExtraWord();
    setReadMode(READ_RANDOM);
    waitDrained();

    if (wordsRead != wordsWritten) begin
      $display("%0t: %0d words were written but %0d were read", $time, wordsWritten, wordsRead);
      errors++;
    end
    $display("Words written %0d, words read %0d, errors %0d", wordsWritten, wordsRead, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Budget of 40 time units per word plus room for reset and the full test
  initial begin
    #(WATCHDOG_TIME);
    $display("Watchdog expired at %0t with %0d words still expected", $time, refQueue.size());
    $display("Done: errors found");
    $finish;
  end

endmodule

// File: verification/tbClockGen.sv
/*
  Free-running testbench clock that starts low.
  An odd PERIOD is rounded down to an even number of time units.
*/
module tbClockGen #(
  parameter int PERIOD = 10
) (
  output logic clk
);

  // Each phase of the clock lasts half the period
  localparam int HALF_PERIOD = PERIOD / 2;

  // The first rising edge comes half a period after time zero
  initial begin
    clk = 1'b0;
    forever begin
      #(HALF_PERIOD) clk = ~clk;
    end
  end

endmodule

// File: source/dcFifoTop.sv
/*
  One rst drives both domains and must be held for several edges of each clock.
  Depth is 2**ADDR_WIDTH in memory plus two words held on the read side.
*/
module dcFifoTop #(
  parameter int ADDR_WIDTH = 4
) (
  input  logic               wrClk,
  input  logic               rdClk,
  input  logic               rst,
  // Host side write port in the wrClk domain
  input  logic               wrValid,
  output logic               wrReady,
  input  fifoPkg::fifoWord_t wrWord,
  // Serial engine read port in the rdClk domain
  output logic               rdValid,
  input  logic               rdReady,
  output fifoPkg::fifoWord_t rdWord
);

  ////////////////////////////////////////////////////////////
  // Internal wiring
  ////////////////////////////////////////////////////////////

  // Gray pointers in their own domain and after crossing over
  logic [ADDR_WIDTH:0]   wrPtrGray;
  logic [ADDR_WIDTH:0]   rdPtrGray;
  logic [ADDR_WIDTH:0]   wrPtrGraySync;
  logic [ADDR_WIDTH:0]   rdPtrGraySync;
  // Memory ports
  logic [ADDR_WIDTH-1:0] memWrAddr;
  logic [ADDR_WIDTH-1:0] memRdAddr;
  logic                  memWriteEn;
  fifoPkg::fifoWord_t    memWrWord;
  fifoPkg::fifoWord_t    memRdWord;

  fifoWriteSide #(.ADDR_WIDTH(ADDR_WIDTH)) writeSide_i (
    .wrClk        (wrClk),
    .rst          (rst),
    .wrValid      (wrValid),
    .wrReady      (wrReady),
    .wrWord       (wrWord),
    .rdPtrGraySync(rdPtrGraySync),
    .wrPtrGray    (wrPtrGray),
    .memAddr      (memWrAddr),
    .memWriteEn   (memWriteEn),
    .memWord      (memWrWord)
  );

  dpMemDc #(.ADDR_WIDTH(ADDR_WIDTH)) mem_i (
    .wrClk  (wrClk),
    .rdClk  (rdClk),
    .addrIn (memWrAddr),
    .addrOut(memRdAddr),
    .writeEn(memWriteEn),
    .dataIn (memWrWord),
    .dataOut(memRdWord)
  );

  // Write pointer crosses into the read domain for the empty check
  grayPtrSync #(.ADDR_WIDTH(ADDR_WIDTH)) wrPtrSync_i (
    .clk   (rdClk),
    .rst   (rst),
    .ptrIn (wrPtrGray),
    .ptrOut(wrPtrGraySync)
  );

  // Read pointer crosses into the write domain for the full check
  grayPtrSync #(.ADDR_WIDTH(ADDR_WIDTH)) rdPtrSync_i (
    .clk   (wrClk),
    .rst   (rst),
    .ptrIn (rdPtrGray),
    .ptrOut(rdPtrGraySync)
  );

  fifoReadSide #(.ADDR_WIDTH(ADDR_WIDTH)) readSide_i (
    .rdClk        (rdClk),
    .rst          (rst),
    .wrPtrGraySync(wrPtrGraySync),
    .rdPtrGray    (rdPtrGray),
    .memAddr      (memRdAddr),
    .memWord      (memRdWord),
    .rdValid      (rdValid),
    .rdReady      (rdReady),
    .rdWord       (rdWord)
  );

endmodule

// File: source/fifoReadSide.sv
/*
  Runs entirely in the rdClk domain and samples rst synchronously.
  Holds up to two words beyond the memory, so the FIFO accepts depth plus two words.
*/
module fifoReadSide #(
  parameter int ADDR_WIDTH = 4
) (
  input  logic                  rdClk,
  input  logic                  rst,
  input  logic [ADDR_WIDTH:0]   wrPtrGraySync,
  output logic [ADDR_WIDTH:0]   rdPtrGray,
  output logic [ADDR_WIDTH-1:0] memAddr,
  input  fifoPkg::fifoWord_t    memWord,
  output logic                  rdValid,
  input  logic                  rdReady,
  output fifoPkg::fifoWord_t    rdWord
);

  ////////////////////////////////////////////////////////////
  // Read pointer and fetch control
  ////////////////////////////////////////////////////////////

  logic [ADDR_WIDTH:0] rdPtrBin;
  logic [ADDR_WIDTH:0] rdPtrBinNext;
  logic                empty;
  // Set when a memory word lands on memWord this cycle
  logic                fetchPending;
  logic                fetch;
  logic                pop;
  // Words held after this edge, counting the landing word and the one consumed
  logic [1:0]          slotsCommitted;

  fifoPkg::rdState_e   state;
  fifoPkg::rdState_e   stateNext;
  // Prefetch register behind the output register
  fifoPkg::fifoWord_t  prefetchWord;

  // Steering of the two payload registers
  logic loadOutFromMem;
  logic loadOutFromPrefetch;
  logic loadPrefetch;

  // Empty when the reader has caught up with the synchronized writer
  assign empty = (rdPtrGray == wrPtrGraySync);
  assign pop   = rdValid & rdReady;

  // The state encoding is the count of words held in the output stages
  assign slotsCommitted = state + {1'b0, fetchPending} - {1'b0, pop};

  // Fetch only when the new word is sure to find a free slot next cycle
  assign fetch = ~empty & (slotsCommitted <= 2'd1);

  assign rdPtrBinNext = rdPtrBin + 1'b1;
  assign memAddr      = rdPtrBin[ADDR_WIDTH-1:0];

  always_ff @(posedge rdClk) begin
    if (rst) begin
      rdPtrBin     <= '0;
      rdPtrGray    <= '0;
      fetchPending <= 1'b0;
    end else begin
      fetchPending <= fetch;
      if (fetch) begin
        rdPtrBin  <= rdPtrBinNext;
        rdPtrGray <= rdPtrBinNext ^ (rdPtrBinNext >> 1);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Output stages
  ////////////////////////////////////////////////////////////

  always_comb begin
    stateNext           = state;
    loadOutFromMem      = 1'b0;
    loadOutFromPrefetch = 1'b0;
    loadPrefetch        = 1'b0;
    case (state)
      fifoPkg::RD_EMPTY: begin
        if (fetchPending) begin
          loadOutFromMem = 1'b1;
          stateNext      = fifoPkg::RD_ONE;
        end
      end
      fifoPkg::RD_ONE: begin
        // A landing word replaces a consumed one or queues behind it
        if (fetchPending && pop) begin
          loadOutFromMem = 1'b1;
        end else if (fetchPending) begin
          loadPrefetch = 1'b1;
          stateNext    = fifoPkg::RD_TWO;
        end else if (pop) begin
          stateNext = fifoPkg::RD_EMPTY;
        end
      end
      fifoPkg::RD_TWO: begin
        // The prefetched word moves up first to keep the order
        // No word lands here since the fetch check keeps a slot free for it
        if (pop) begin
          loadOutFromPrefetch = 1'b1;
          stateNext           = fifoPkg::RD_ONE;
        end
      end
      default: begin
        stateNext = fifoPkg::RD_EMPTY;
      end
    endcase
  end

  always_ff @(posedge rdClk) begin
    if (rst) begin
      state <= fifoPkg::RD_EMPTY;
    end else begin
      state <= stateNext;
    end
  end

  // Payload registers only move under the steering signals
  // So rdWord holds while the consumer stalls
  always_ff @(posedge rdClk) begin
    if (loadOutFromMem) begin
      rdWord <= memWord;
    end else if (loadOutFromPrefetch) begin
      rdWord <= prefetchWord;
    end
    if (loadPrefetch) begin
      prefetchWord <= memWord;
    end
  end

  assign rdValid = (state != fifoPkg::RD_EMPTY);

endmodule

// File: source/fifoWriteSide.sv
/*
  Runs entirely in the wrClk domain and samples rst synchronously.
  Space freed by the reader shows up 2 to 3 wrClk cycles after the read pointer moves.
*/
module fifoWriteSide #(
  parameter int ADDR_WIDTH = 4
) (
  input  logic                  wrClk,
  input  logic                  rst,
  input  logic                  wrValid,
  output logic                  wrReady,
  input  fifoPkg::fifoWord_t    wrWord,
  input  logic [ADDR_WIDTH:0]   rdPtrGraySync,
  output logic [ADDR_WIDTH:0]   wrPtrGray,
  output logic [ADDR_WIDTH-1:0] memAddr,
  output logic                  memWriteEn,
  output fifoPkg::fifoWord_t    memWord
);

  ////////////////////////////////////////////////////////////
  // Pointers
  ////////////////////////////////////////////////////////////

  // Binary pointer carries one extra wrap bit above the address
  logic [ADDR_WIDTH:0] wrPtrBin;
  logic [ADDR_WIDTH:0] wrPtrBinNext;
  logic [ADDR_WIDTH:0] wrPtrGrayNext;
  // Read pointer with its two top bits flipped to match a full write pointer
  logic [ADDR_WIDTH:0] rdPtrGrayWrapped;
  logic                full;
  logic                accept;

  // A word moves when the sender offers it and there is room
  assign accept = wrValid & wrReady;

  assign wrPtrBinNext  = wrPtrBin + 1'b1;
  assign wrPtrGrayNext = wrPtrBinNext ^ (wrPtrBinNext >> 1);

  // The write pointer is a full lap ahead of the read pointer when full
  // In Gray code that means the top two bits differ and the rest match
  assign rdPtrGrayWrapped = {~rdPtrGraySync[ADDR_WIDTH:ADDR_WIDTH-1],
                             rdPtrGraySync[ADDR_WIDTH-2:0]};
  assign full             = (wrPtrGray == rdPtrGrayWrapped);

  // Ready is the inverse of full so a full FIFO ignores wrValid
  assign wrReady = ~full;

  // Both pointers step together on each accepted word
  // Full is computed from the updated registers on the very next cycle
  always_ff @(posedge wrClk) begin
    if (rst) begin
      wrPtrBin  <= '0;
      wrPtrGray <= '0;
    end else if (accept) begin
      wrPtrBin  <= wrPtrBinNext;
      wrPtrGray <= wrPtrGrayNext;
    end
  end

  ////////////////////////////////////////////////////////////
  // Memory write port
  ////////////////////////////////////////////////////////////

  // The low bits of the binary pointer address the memory directly
  assign memAddr    = wrPtrBin[ADDR_WIDTH-1:0];
  assign memWriteEn = accept;
  // The word goes straight through since the memory registers it on wrClk
  assign memWord    = wrWord;

  // The Gray pointer only becomes visible to the reader after the write edge
  // So the stored word is always settled before the reader can fetch it

endmodule

// File: source/grayPtrSync.sv
/*
  Only safe for Gray-coded inputs where one bit changes per source edge.
  The output lags the input by two destination clock edges.
*/
module grayPtrSync #(
  parameter int ADDR_WIDTH = 4
) (
  input  logic                clk,
  input  logic                rst,
  input  logic [ADDR_WIDTH:0] ptrIn,
  output logic [ADDR_WIDTH:0] ptrOut
);

  ////////////////////////////////////////////////////////////
  // Two-flop synchronizer
  ////////////////////////////////////////////////////////////

  // First stage may go metastable when ptrIn changes near the clock edge
  logic [ADDR_WIDTH:0] syncStage;

  // The first stage samples the foreign pointer
  // The second stage gives it a full cycle to settle before use
  // Because the pointer is Gray coded, a late sample is either the old
  // Or the new value and never a mix of the two
  always_ff @(posedge clk) begin
    if (rst) begin
      syncStage <= '0;
      ptrOut    <= '0;
    end else begin
      syncStage <= ptrIn;
      ptrOut    <= syncStage;
    end
  end

  // Both stages clear together so the pointer compares
  // On each side agree right after reset
  // The reset must span enough edges of both clocks to reach this point
  // With the source pointer already at zero

endmodule

// File: source/dpMemDc.sv
/*
  Contents are undefined until written, and there is no reset.
  A read in the same rdClk cycle as a write to that address may return old data.
*/
module dpMemDc #(
  parameter int ADDR_WIDTH = 4
) (
  input  logic                  wrClk,
  input  logic                  rdClk,
  input  logic [ADDR_WIDTH-1:0] addrIn,
  input  logic [ADDR_WIDTH-1:0] addrOut,
  input  logic                  writeEn,
  input  fifoPkg::fifoWord_t    dataIn,
  output fifoPkg::fifoWord_t    dataOut
);

  // Storage holds 2**ADDR_WIDTH words
  fifoPkg::fifoWord_t mem [2**ADDR_WIDTH];

  // Write port runs in the host clock domain
  always_ff @(posedge wrClk) begin
    if (writeEn) begin
      mem[addrIn] <= dataIn;
    end
  end

  // Read port is registered on every rdClk edge
  // The word at addrOut appears on dataOut one edge later
  always_ff @(posedge rdClk) begin
    dataOut <= mem[addrOut];
  end

endmodule

// File: source/fifoPkg.sv
/*
  Word format shared by the dual-clock FIFO and its testbench.
  The depth is not set here but by the ADDR_WIDTH module parameter.
*/
package fifoPkg;

  ////////////////////////////////////////////////////////////
  // Word format
  ////////////////////////////////////////////////////////////

  // Payload width of one SPI byte
  localparam int WORD_WIDTH = 8;

  // One stored word of 9 bits
  // The frame flag sits above the data so that the data stays in the low bits
  typedef struct packed {
    // Marks the final byte of a SPI frame
    logic                  last;
    // Byte carried to or from the serial engine
    logic [WORD_WIDTH-1:0] data;
  } fifoWord_t;

  ////////////////////////////////////////////////////////////
  // Read side output stages
  ////////////////////////////////////////////////////////////

  // The encoding equals the number of words held in the output stages
  // The read side uses this to count its occupied slots
  typedef enum logic [1:0] {
    // Neither the output register nor the prefetch register holds a word
    RD_EMPTY = 2'd0,
    // Only the output register holds a word
    RD_ONE   = 2'd1,
    // The output register and the prefetch register both hold a word
    RD_TWO   = 2'd2
  } rdState_e;

endpackage
